//--- cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// byte addresses toward memory
`define CU_ADDR_WIDTH 32
// vertex and edge counts
`define CU_COUNT_WIDTH 32
`define CU_DEGREE_WIDTH 16
`define CU_ID_WIDTH 2

//////////////////////////////////////////////////////////////////////
// compute-unit ids carried in the read tag
//////////////////////////////////////////////////////////////////////

`define CU_VERTEX_CONTROL_ID 1
`define CU_EDGE_READER_ID 2

// record sizes in memory, in bytes
`define VERTEX_RECORD_BYTES 8
`define EDGE_BYTES 4

// vertex reads outstanding plus records waiting in the queue
`define VERTEX_QUEUE_DEPTH 4

`endif

//--- cu_pkg.sv
`include "cu_consts.svh"

package cu_pkg;

	typedef logic [`CU_ADDR_WIDTH-1:0] address_t;

	// vertex and edge totals
	typedef logic [`CU_COUNT_WIDTH-1:0] count_t;

	//////////////////////////////////////////////////////////////////////
	// read command side
	//////////////////////////////////////////////////////////////////////

	// value is the vertex index for vertex reads, the out-degree for edge reads
	typedef struct packed {
		logic [`CU_ID_WIDTH-1:0]     cu_id;
		logic [`CU_DEGREE_WIDTH-1:0] value;
	} read_tag_t;

	typedef struct packed {
		address_t  address;
		read_tag_t tag;
	} read_command_t;

	//////////////////////////////////////////////////////////////////////
	// read return data
	//////////////////////////////////////////////////////////////////////

	// one 64-bit data line holds one vertex record
	typedef struct packed {
		logic [`CU_DEGREE_WIDTH-1:0] in_degree;
		logic [`CU_DEGREE_WIDTH-1:0] out_degree;
		// first edge of this vertex in the edge array
		logic [`CU_COUNT_WIDTH-1:0]  edge_index;
	} vertex_record_t;

endpackage

//--- cu_job_control.sv
`include "cu_consts.svh"

module cu_job_control (
	input  logic             clock,
	input  logic             rstn,
	input  logic             enabled,
	input  logic             wed_valid,
	input  cu_pkg::count_t   num_vertices,
	input  cu_pkg::count_t   num_edges,
	input  cu_pkg::address_t vertex_base,
	input  cu_pkg::address_t edge_base,
	input  cu_pkg::count_t   vertices_filtered,
	input  cu_pkg::count_t   vertices_done,
	input  cu_pkg::count_t   edges_done,
	output logic             run,
	output cu_pkg::count_t   job_vertices,
	output cu_pkg::address_t job_vertex_base,
	output cu_pkg::address_t job_edge_base,
	output logic             cu_done,
	output cu_pkg::count_t   return_vertices,
	output cu_pkg::count_t   return_edges
);

	logic                       start;
	logic [`CU_COUNT_WIDTH-1:0] job_edges;

	// first cycle with enabled and a valid work descriptor
	assign start = enabled && wed_valid && !run;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			run <= 1'b0;
		end else if (!enabled) begin
			run <= 1'b0;
		end else if (start) begin
			run <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			job_vertices    <= num_vertices;
			job_edges       <= num_edges;
			job_vertex_base <= vertex_base;
			job_edge_base   <= edge_base;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// totals and done
	//////////////////////////////////////////////////////////////////////

	// totals lag the unit counters by one cycle, done lags the totals by one
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			return_vertices <= '0;
			return_edges    <= '0;
			cu_done         <= 1'b0;
		end else if (!enabled) begin
			return_vertices <= '0;
			return_edges    <= '0;
			cu_done         <= 1'b0;
		end else begin
			return_vertices <= vertices_done + vertices_filtered;
			return_edges    <= edges_done;
			cu_done         <= run && (return_vertices == job_vertices) &&
				(return_edges == job_edges);
		end
	end

endmodule

//--- read_return_router.sv
`include "cu_consts.svh"

module read_return_router (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   run,
	input  logic                   read_return_valid,
	input  cu_pkg::read_tag_t      read_return_tag,
	input  cu_pkg::vertex_record_t read_return_data,
	output logic                   vertex_return_valid,
	output logic                   edge_return_valid,
	output cu_pkg::read_tag_t      return_tag,
	output cu_pkg::vertex_record_t return_data
);

	// steer by compute-unit id, anything not vertex control goes to the edge side
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_return_valid <= 1'b0;
			edge_return_valid   <= 1'b0;
		end else if (run && read_return_valid) begin
			case (read_return_tag.cu_id)
				`CU_ID_WIDTH'(`CU_VERTEX_CONTROL_ID): begin
					vertex_return_valid <= 1'b1;
					edge_return_valid   <= 1'b0;
				end
				default: begin
					vertex_return_valid <= 1'b0;
					edge_return_valid   <= 1'b1;
				end
			endcase
		end else begin
			vertex_return_valid <= 1'b0;
			edge_return_valid   <= 1'b0;
		end
	end

	// tag and data are shared by both destinations
	always_ff @(posedge clock) begin
		return_tag  <= read_return_tag;
		return_data <= read_return_data;
	end

endmodule

//--- vertex_job_reader.sv
`include "cu_consts.svh"

module vertex_job_reader (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   run,
	input  cu_pkg::count_t         job_vertices,
	input  cu_pkg::address_t       job_vertex_base,
	input  logic                   grant,
	input  logic                   vertex_return_valid,
	input  cu_pkg::vertex_record_t return_data,
	input  logic                   vertex_request,
	output logic                   request,
	output cu_pkg::read_command_t  command,
	output logic                   vertex_valid,
	output cu_pkg::vertex_record_t vertex_record
);

	localparam int DEPTH       = `VERTEX_QUEUE_DEPTH;
	localparam int PTR_WIDTH   = $clog2(DEPTH);
	localparam int LEVEL_WIDTH = $clog2(DEPTH + 1);

	cu_pkg::count_t         issue_index;
	logic [LEVEL_WIDTH-1:0] in_flight;
	logic [LEVEL_WIDTH-1:0] fifo_count;
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic                   pending;
	logic                   pop;
	cu_pkg::vertex_record_t fifo_mem [DEPTH];

	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_WIDTH'(1);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// read command generation
	//////////////////////////////////////////////////////////////////////

	// in_flight counts reads issued and not yet handed to the filter
	assign request = run && (issue_index < job_vertices) &&
		(in_flight < LEVEL_WIDTH'(DEPTH));

	assign command.address = job_vertex_base +
		cu_pkg::address_t'(issue_index) * cu_pkg::address_t'(`VERTEX_RECORD_BYTES);
	assign command.tag.cu_id = `CU_ID_WIDTH'(`CU_VERTEX_CONTROL_ID);
	assign command.tag.value = issue_index[`CU_DEGREE_WIDTH-1:0];

	// a request waiting here is served as soon as a record is queued
	assign pop = run && (pending || vertex_request) && (fifo_count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_index  <= '0;
			in_flight    <= '0;
			fifo_count   <= '0;
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			pending      <= 1'b0;
			vertex_valid <= 1'b0;
		end else if (!run) begin
			issue_index  <= '0;
			in_flight    <= '0;
			fifo_count   <= '0;
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			pending      <= 1'b0;
			vertex_valid <= 1'b0;
		end else begin
			if (grant) begin
				issue_index <= issue_index + cu_pkg::count_t'(1);
			end
			in_flight  <= in_flight + LEVEL_WIDTH'(grant) - LEVEL_WIDTH'(pop);
			fifo_count <= fifo_count + LEVEL_WIDTH'(vertex_return_valid) - LEVEL_WIDTH'(pop);
			if (vertex_return_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			vertex_valid <= pop;
			if (pop) begin
				pending <= 1'b0;
			end else if (vertex_request) begin
				pending <= 1'b1;
			end
		end
	end

	// records queue in arrival order
	always_ff @(posedge clock) begin
		if (vertex_return_valid) begin
			fifo_mem[wr_ptr] <= return_data;
		end
		if (pop) begin
			vertex_record <= fifo_mem[rd_ptr];
		end
	end

endmodule

//--- vertex_job_filter.sv
`include "cu_consts.svh"

module vertex_job_filter (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   run,
	input  logic                   vertex_valid,
	input  cu_pkg::vertex_record_t vertex_record,
	input  logic                   edge_ready,
	output logic                   vertex_request,
	output logic                   vertex_out_valid,
	output cu_pkg::vertex_record_t vertex_out,
	output cu_pkg::count_t         vertices_filtered
);

	logic pending;
	logic keep;

	// a vertex nobody points to has nothing to contribute
	assign keep = vertex_record.in_degree != `CU_DEGREE_WIDTH'(0);

	// one request at a time, only while the edge reader is idle
	assign vertex_request = run && edge_ready && !pending;

	// forwarded in the same cycle so the edge reader is busy before the next request
	assign vertex_out_valid = run && vertex_valid && keep;
	assign vertex_out       = vertex_record;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending           <= 1'b0;
			vertices_filtered <= '0;
		end else if (!run) begin
			pending           <= 1'b0;
			vertices_filtered <= '0;
		end else begin
			if (vertex_valid) begin
				pending <= 1'b0;
			end else if (vertex_request) begin
				pending <= 1'b1;
			end
			if (vertex_valid && !keep) begin
				vertices_filtered <= vertices_filtered + cu_pkg::count_t'(1);
			end
		end
	end

endmodule

//--- edge_list_reader.sv
`include "cu_consts.svh"

module edge_list_reader (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   run,
	input  cu_pkg::address_t       edge_base,
	input  logic                   vertex_out_valid,
	input  cu_pkg::vertex_record_t vertex_out,
	input  logic                   grant,
	input  logic                   edge_return_valid,
	input  cu_pkg::read_tag_t      return_tag,
	output logic                   edge_ready,
	output logic                   request,
	output cu_pkg::read_command_t  command,
	output cu_pkg::count_t         vertices_done,
	output cu_pkg::count_t         edges_done
);

	logic busy;
	logic accept;

	assign edge_ready = !busy;
	assign request    = busy;
	assign accept     = !busy && vertex_out_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
		end else if (!run) begin
			busy <= 1'b0;
		end else if (busy && grant) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end
	end

	// edge list read, out-degree rides along in the tag
	always_ff @(posedge clock) begin
		if (accept) begin
			command.address <= edge_base +
				cu_pkg::address_t'(vertex_out.edge_index) * cu_pkg::address_t'(`EDGE_BYTES);
			command.tag.cu_id <= `CU_ID_WIDTH'(`CU_EDGE_READER_ID);
			command.tag.value <= vertex_out.out_degree;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// completion counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertices_done <= '0;
			edges_done    <= '0;
		end else if (!run) begin
			vertices_done <= '0;
			edges_done    <= '0;
		end else if (edge_return_valid) begin
			vertices_done <= vertices_done + cu_pkg::count_t'(1);
			edges_done    <= edges_done + cu_pkg::count_t'(return_tag.value);
		end
	end

endmodule

//--- read_command_arbiter.sv
`include "cu_consts.svh"

module read_command_arbiter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  run,
	input  logic                  vertex_request,
	input  cu_pkg::read_command_t vertex_command,
	input  logic                  edge_request,
	input  cu_pkg::read_command_t edge_command,
	input  logic                  read_buffer_alfull,
	output logic                  vertex_grant,
	output logic                  edge_grant,
	output logic                  read_command_valid,
	output cu_pkg::read_command_t read_command
);

	logic last_edge;
	logic allow;

	// one command every other cycle so each valid is a single-cycle pulse
	assign allow = run && !read_buffer_alfull && !read_command_valid;

	// last winner drops to low priority
	assign vertex_grant = allow && vertex_request && (!edge_request || last_edge);
	assign edge_grant   = allow && edge_request && (!vertex_request || !last_edge);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
			last_edge          <= 1'b0;
		end else if (!run) begin
			read_command_valid <= 1'b0;
			last_edge          <= 1'b0;
		end else begin
			read_command_valid <= vertex_grant || edge_grant;
			if (vertex_grant) begin
				last_edge <= 1'b0;
			end else if (edge_grant) begin
				last_edge <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outgoing command register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (edge_grant) begin
			read_command <= edge_command;
		end else if (vertex_grant) begin
			read_command <= vertex_command;
		end
	end

endmodule

//--- cu_control_top.sv
module cu_control_top (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   wed_valid,
	input  cu_pkg::count_t         num_vertices,
	input  cu_pkg::count_t         num_edges,
	input  cu_pkg::address_t       vertex_base,
	input  cu_pkg::address_t       edge_base,
	output logic                   read_command_valid,
	output cu_pkg::read_command_t  read_command,
	input  logic                   read_buffer_alfull,
	input  logic                   read_return_valid,
	input  cu_pkg::read_tag_t      read_return_tag,
	input  cu_pkg::vertex_record_t read_return_data,
	output logic                   cu_done,
	output cu_pkg::count_t         return_vertices,
	output cu_pkg::count_t         return_edges
);

	logic                   run;
	cu_pkg::count_t         job_vertices;
	cu_pkg::address_t       job_vertex_base;
	cu_pkg::address_t       job_edge_base;
	logic                   vertex_return_valid;
	logic                   edge_return_valid;
	cu_pkg::read_tag_t      return_tag;
	cu_pkg::vertex_record_t return_data;
	logic                   vertex_read_request;
	logic                   vertex_read_grant;
	cu_pkg::read_command_t  vertex_read_command;
	logic                   edge_read_request;
	logic                   edge_read_grant;
	cu_pkg::read_command_t  edge_read_command;
	logic                   vertex_request;
	logic                   vertex_valid;
	cu_pkg::vertex_record_t vertex_record;
	logic                   edge_ready;
	logic                   vertex_out_valid;
	cu_pkg::vertex_record_t vertex_out;
	cu_pkg::count_t         vertices_filtered;
	cu_pkg::count_t         vertices_done;
	cu_pkg::count_t         edges_done;

	//////////////////////////////////////////////////////////////////////
	// job control and return routing
	//////////////////////////////////////////////////////////////////////

	cu_job_control job_control_i (
		.clock(clock), .rstn(rstn), .enabled(enabled), .wed_valid(wed_valid),
		.num_vertices(num_vertices), .num_edges(num_edges),
		.vertex_base(vertex_base), .edge_base(edge_base),
		.vertices_filtered(vertices_filtered), .vertices_done(vertices_done),
		.edges_done(edges_done), .run(run), .job_vertices(job_vertices),
		.job_vertex_base(job_vertex_base), .job_edge_base(job_edge_base),
		.cu_done(cu_done), .return_vertices(return_vertices), .return_edges(return_edges)
	);

	read_return_router return_router_i (
		.clock(clock), .rstn(rstn), .run(run), .read_return_valid(read_return_valid),
		.read_return_tag(read_return_tag), .read_return_data(read_return_data),
		.vertex_return_valid(vertex_return_valid), .edge_return_valid(edge_return_valid),
		.return_tag(return_tag), .return_data(return_data)
	);

	//////////////////////////////////////////////////////////////////////
	// vertex path, filter, edge reads
	//////////////////////////////////////////////////////////////////////

	vertex_job_reader vertex_reader_i (
		.clock(clock), .rstn(rstn), .run(run), .job_vertices(job_vertices),
		.job_vertex_base(job_vertex_base), .grant(vertex_read_grant),
		.vertex_return_valid(vertex_return_valid), .return_data(return_data),
		.vertex_request(vertex_request), .request(vertex_read_request),
		.command(vertex_read_command), .vertex_valid(vertex_valid),
		.vertex_record(vertex_record)
	);

	vertex_job_filter vertex_filter_i (
		.clock(clock), .rstn(rstn), .run(run), .vertex_valid(vertex_valid),
		.vertex_record(vertex_record), .edge_ready(edge_ready),
		.vertex_request(vertex_request), .vertex_out_valid(vertex_out_valid),
		.vertex_out(vertex_out), .vertices_filtered(vertices_filtered)
	);

	edge_list_reader edge_reader_i (
		.clock(clock), .rstn(rstn), .run(run), .edge_base(job_edge_base),
		.vertex_out_valid(vertex_out_valid), .vertex_out(vertex_out),
		.grant(edge_read_grant), .edge_return_valid(edge_return_valid),
		.return_tag(return_tag), .edge_ready(edge_ready), .request(edge_read_request),
		.command(edge_read_command), .vertices_done(vertices_done), .edges_done(edges_done)
	);

	// single outgoing read command port
	read_command_arbiter command_arbiter_i (
		.clock(clock), .rstn(rstn), .run(run),
		.vertex_request(vertex_read_request), .vertex_command(vertex_read_command),
		.edge_request(edge_read_request), .edge_command(edge_read_command),
		.read_buffer_alfull(read_buffer_alfull), .vertex_grant(vertex_read_grant),
		.edge_grant(edge_read_grant), .read_command_valid(read_command_valid),
		.read_command(read_command)
	);

endmodule

//--- cu_control_properties.sv
module cu_control_properties (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input logic read_buffer_alfull,
	input logic read_command_valid,
	input logic cu_done
);

	//////////////////////////////////////////////////////////////////////
	// read command port
	//////////////////////////////////////////////////////////////////////

	// a command only follows a cycle with room in the read buffer
	command_after_room: assert property (
		@(posedge clock) disable iff (!rstn)
		read_command_valid |-> !$past(read_buffer_alfull)
	) else $error("read command after an almost-full cycle");

	command_single_cycle: assert property (
		@(posedge clock) disable iff (!rstn)
		read_command_valid |=> !read_command_valid
	) else $error("read command valid for two cycles");

	// done clears once the unit is disabled
	done_cleared: assert property (
		@(posedge clock) disable iff (!rstn)
		!enabled |=> !cu_done
	) else $error("cu_done high after enabled was low");

endmodule

bind cu_control_top cu_control_properties props_i (
	.clock(clock), .rstn(rstn), .enabled(enabled),
	.read_buffer_alfull(read_buffer_alfull), .read_command_valid(read_command_valid),
	.cu_done(cu_done)
);

//--- cu_control_tb.sv
`include "cu_consts.svh"

module cu_control_tb;

	localparam int TIMEOUT_CYCLES = 4000;

	logic                   clock = 1'b0;
	logic                   rstn;
	logic                   enabled;
	logic                   wed_valid;
	cu_pkg::count_t         num_vertices;
	cu_pkg::count_t         num_edges;
	cu_pkg::address_t       vertex_base;
	cu_pkg::address_t       edge_base;
	logic                   read_command_valid;
	cu_pkg::read_command_t  read_command;
	logic                   read_buffer_alfull;
	logic                   read_return_valid;
	cu_pkg::read_tag_t      read_return_tag;
	cu_pkg::vertex_record_t read_return_data;
	logic                   cu_done;
	cu_pkg::count_t         return_vertices;
	cu_pkg::count_t         return_edges;

	cu_pkg::vertex_record_t vertex_table [$];
	cu_pkg::read_command_t  pending [$];
	cu_pkg::read_command_t  edge_expected [$];
	logic [31:0]            lcg_state = 32'd15962;
	int                     value_errors = 0;
	int                     protocol_errors = 0;
	int                     timeout_errors = 0;
	int                     next_vertex = 0;
	int                     edge_reads = 0;
	logic                   reorder;
	logic                   throttle;

	cu_control_top dut_i (
		.clock(clock), .rstn(rstn), .enabled(enabled), .wed_valid(wed_valid),
		.num_vertices(num_vertices), .num_edges(num_edges),
		.vertex_base(vertex_base), .edge_base(edge_base),
		.read_command_valid(read_command_valid), .read_command(read_command),
		.read_buffer_alfull(read_buffer_alfull), .read_return_valid(read_return_valid),
		.read_return_tag(read_return_tag), .read_return_data(read_return_data),
		.cu_done(cu_done), .return_vertices(return_vertices), .return_edges(return_edges)
	);

	always #2 clock = ~clock;

	function automatic int unsigned next_random(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]} % range;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_count(input string name, input cu_pkg::count_t got,
		input cu_pkg::count_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%0d expected=%0d",
				$time, name, got, exp);
		end
	endtask

	task automatic check_command(input string name, input cu_pkg::read_command_t got,
		input cu_pkg::read_command_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp);
		end
	endtask

	// vertex i lives at base plus i records and its tag carries the index
	function automatic cu_pkg::read_command_t vertex_command_for(input int index);
		cu_pkg::read_command_t cmd;
		cmd.address   = vertex_base + cu_pkg::address_t'(index * `VERTEX_RECORD_BYTES);
		cmd.tag.cu_id = `CU_ID_WIDTH'(`CU_VERTEX_CONTROL_ID);
		cmd.tag.value = 16'(index);
		return cmd;
	endfunction

	function automatic cu_pkg::read_command_t edge_command_for(
		input cu_pkg::vertex_record_t rec);
		cu_pkg::read_command_t cmd;
		cmd.address   = edge_base + cu_pkg::address_t'(rec.edge_index) *
			cu_pkg::address_t'(`EDGE_BYTES);
		cmd.tag.cu_id = `CU_ID_WIDTH'(`CU_EDGE_READER_ID);
		cmd.tag.value = rec.out_degree;
		return cmd;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// memory model and almost-full stretches
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : memory_model
		int unsigned           pick;
		int                    index;
		cu_pkg::read_command_t cmd;
		if (read_command_valid) begin
			if (read_command.tag.cu_id == `CU_ID_WIDTH'(`CU_VERTEX_CONTROL_ID)) begin
				if (next_vertex >= vertex_table.size()) begin
					protocol_errors++;
					$display("vertex read beyond the vertex count at time %0t", $time);
				end
				check_command("read_command", read_command, vertex_command_for(next_vertex));
				next_vertex++;
			end else if (edge_expected.size() == 0) begin
				protocol_errors++;
				$display("edge read with no surviving vertex waiting at time %0t", $time);
			end else begin
				check_command("read_command", read_command, edge_expected.pop_front());
				edge_reads++;
			end
			pending.push_back(read_command);
		end
		// answers follow random gaps and may pick any outstanding command when reordering
		if (pending.size() != 0 && next_random(3) == 0) begin
			pick = reorder ? next_random(pending.size()) : 0;
			cmd = pending[pick];
			pending.delete(pick);
			read_return_valid <= 1'b1;
			read_return_tag   <= cmd.tag;
			if (cmd.tag.cu_id == `CU_ID_WIDTH'(`CU_VERTEX_CONTROL_ID)) begin
				index = int'((cmd.address - vertex_base) /
					cu_pkg::address_t'(`VERTEX_RECORD_BYTES));
				read_return_data <= vertex_table[index];
				// surviving vertices reach the edge reader in arrival order
				if (vertex_table[index].in_degree != 16'd0) begin
					edge_expected.push_back(edge_command_for(vertex_table[index]));
				end
			end else begin
				read_return_data <= '0;
			end
		end else begin
			read_return_valid <= 1'b0;
		end
	end

	always @(posedge clock) begin
		if (!throttle) begin
			read_buffer_alfull <= 1'b0;
		end else if (next_random(4) == 0) begin
			read_buffer_alfull <= ~read_buffer_alfull;
		end
	end

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (!cu_done && cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		if (!cu_done) begin
			timeout_errors++;
			$display("timeout waiting for cu_done at time %0t", $time);
		end
	endtask

	// one job from configuration to cleared totals
	// every zero_step-th vertex has no in-edges
	task automatic run_job(input int count, input int zero_step, input cu_pkg::address_t vbase,
		input cu_pkg::address_t ebase);
		cu_pkg::vertex_record_t rec;
		cu_pkg::count_t         edge_total;
		int                     survivors;
		int                     first_edge;
		vertex_table.delete();
		edge_expected.delete();
		edge_total = '0;
		survivors = 0;
		first_edge = 0;
		for (int i = 0; i < count; i++) begin
			rec.in_degree  = 16'(1 + next_random(7));
			rec.out_degree = 16'(next_random(9));
			if (zero_step != 0 && i % zero_step == 0) begin
				rec.in_degree  = 16'd0;
				rec.out_degree = 16'd0;
			end
			rec.edge_index = cu_pkg::count_t'(first_edge);
			first_edge += int'(rec.out_degree);
			vertex_table.push_back(rec);
			if (rec.in_degree != 16'd0) begin
				edge_total += cu_pkg::count_t'(rec.out_degree);
				survivors++;
			end
		end
		next_vertex = 0;
		edge_reads = 0;
		@(posedge clock);
		num_vertices <= cu_pkg::count_t'(count);
		num_edges    <= edge_total;
		vertex_base  <= vbase;
		edge_base    <= ebase;
		enabled      <= 1'b1;
		wed_valid    <= 1'b1;
		@(posedge clock);
		wed_valid <= 1'b0;
		wait_done();
		check_count("return_vertices", return_vertices, cu_pkg::count_t'(count));
		check_count("return_edges", return_edges, edge_total);
		check_count("vertex_reads", cu_pkg::count_t'(next_vertex), cu_pkg::count_t'(count));
		check_count("edge_reads", cu_pkg::count_t'(edge_reads), cu_pkg::count_t'(survivors));
		if (pending.size() != 0) begin
			protocol_errors++;
			$display("reads still outstanding at cu_done, time %0t", $time);
		end
		enabled <= 1'b0;
		repeat (2) @(posedge clock);
		check_bit("cu_done", cu_done, 1'b0);
		check_count("return_vertices", return_vertices, '0);
		check_count("return_edges", return_edges, '0);
	endtask

	initial begin
		rstn = 1'b0;
		enabled = 1'b0;
		wed_valid = 1'b0;
		num_vertices = '0;
		num_edges = '0;
		vertex_base = '0;
		edge_base = '0;
		read_buffer_alfull = 1'b0;
		read_return_valid = 1'b0;
		read_return_tag = '0;
		read_return_data = '0;
		throttle = 1'b0;
		reorder = 1'b0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		repeat (2) @(posedge clock);
		check_bit("read_command_valid", read_command_valid, 1'b0);
		check_bit("cu_done", cu_done, 1'b0);
		check_count("return_vertices", return_vertices, '0);
		check_count("return_edges", return_edges, '0);

		// each job restarts the unit with a new configuration
		run_job(8, 0, 32'h0000_1000, 32'h0010_0000);
		run_job(10, 3, 32'h0000_2000, 32'h0020_0000);
		throttle <= 1'b1;
		run_job(8, 0, 32'h0000_3000, 32'h0030_0000);
		throttle <= 1'b0;
		reorder <= 1'b1;
		run_job(12, 4, 32'h0000_4000, 32'h0040_0000);
		throttle <= 1'b1;
		run_job(16, 5, 32'h0000_5000, 32'h0050_0000);

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+.
cu_pkg.sv
cu_job_control.sv
read_return_router.sv
vertex_job_reader.sv
vertex_job_filter.sv
edge_list_reader.sv
read_command_arbiter.sv
cu_control_top.sv
cu_control_properties.sv
cu_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run, pass only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cu_control_tb -f build.f -o cu_control_sim

output=$(./obj_dir/cu_control_sim)
echo "$output"

echo "$output" | grep -q "^Test OK$"
